//--- hps_bus_pkg.sv
// host word bus package with word types and command codes for both channels
package hps_bus_pkg;

	//////////////////////////////
	// bus types
	//////////////////////////////

	// one word on the host bus
	typedef logic [15:0] word_t;

	// word position in a transfer, saturates at 15
	typedef logic [3:0] word_idx_t;

	//////////////////////////////
	// user-io commands
	//////////////////////////////

	localparam word_t CMD_CFG        = 16'h0001;
	localparam word_t CMD_JOY0       = 16'h0002;
	localparam word_t CMD_JOY1       = 16'h0003;
	localparam word_t CMD_JOY2       = 16'h0010;
	localparam word_t CMD_JOY3       = 16'h0011;
	localparam word_t CMD_JOY4       = 16'h0012;
	localparam word_t CMD_JOY5       = 16'h0013;
	localparam word_t CMD_STATUS     = 16'h001e;
	localparam word_t CMD_STATUS_REQ = 16'h0029;
	localparam word_t CMD_MENUMASK   = 16'h002e;

	//////////////////////////////
	// file-io commands
	//////////////////////////////

	localparam word_t FIO_FILE_TX     = 16'h0053;
	localparam word_t FIO_FILE_TX_DAT = 16'h0054;
	localparam word_t FIO_FILE_INDEX  = 16'h0055;
	localparam word_t FIO_FILE_INFO   = 16'h0056;

	// upper nibble of the status request reply
	localparam logic [3:0] STATUS_REQ_TAG = 4'ha;

endpackage

//--- hps_core_pkg.sv
// core-side package with output word types and download path constants
package hps_core_pkg;

	//////////////////////////////
	// register types
	//////////////////////////////

	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;
	typedef logic [15:0] cfg_t;

	//////////////////////////////
	// download path
	//////////////////////////////

	// byte address, 128 MB range
	typedef logic [26:0] ioctl_addr_t;
	typedef logic [15:0] ioctl_data_t;
	typedef logic [31:0] file_ext_t;

	// 16-bit words, so two bytes per word
	localparam ioctl_addr_t ADDR_STEP = 27'd2;

	localparam int BUF_DEPTH = 4;

	typedef logic [1:0] credit_t;
	typedef logic [2:0] buf_cnt_t;

	// credits granted to the core out of reset
	localparam credit_t CORE_CREDITS = 2'd2;

endpackage

//--- hps_cmd_framer.sv
// command framer that tracks the command and word index of one enable-framed channel
module hps_cmd_framer (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic                  enable,
	input  logic                  strobe,
	input  hps_bus_pkg::word_t    din,
	output logic                  word_stb,
	output hps_bus_pkg::word_t    cmd,
	output hps_bus_pkg::word_idx_t word_idx
);

	import hps_bus_pkg::*;

	word_idx_t cnt_q;
	word_t     cmd_q;

	// strobes outside this channel's transfer are not ours
	assign word_stb = enable & strobe;

	//////////////////////////////
	// word counter
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cnt_q <= '0;
		end else if (!enable) begin
			// enable low closes the transfer
			cnt_q <= '0;
		end else if (strobe && (cnt_q != '1)) begin
			cnt_q <= cnt_q + 4'd1;
		end
	end

	//////////////////////////////
	// command capture
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cmd_q <= '0;
		end else if (!enable) begin
			cmd_q <= '0;
		end else if (strobe && (cnt_q == '0)) begin
			// first word of the transfer
			cmd_q <= din;
		end
	end

	assign cmd = cmd_q;

	// idle channel reads as word 0 right away
	assign word_idx = enable ? cnt_q : '0;

endmodule

//--- uio_regs.sv
// user-io register file with joysticks, status, cfg, status request capture and readback
module uio_regs (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   word_stb,
	input  hps_bus_pkg::word_t     cmd,
	input  hps_bus_pkg::word_idx_t word_idx,
	input  hps_bus_pkg::word_t     din,
	input  hps_core_pkg::status_t  status_in,
	input  logic                   status_set,
	input  hps_bus_pkg::word_t     status_menumask,
	output hps_bus_pkg::word_t     io_dout,
	output hps_core_pkg::joy_t     joystick_0,
	output hps_core_pkg::joy_t     joystick_1,
	output hps_core_pkg::joy_t     joystick_2,
	output hps_core_pkg::joy_t     joystick_3,
	output hps_core_pkg::joy_t     joystick_4,
	output hps_core_pkg::joy_t     joystick_5,
	output hps_core_pkg::status_t  status,
	output logic [1:0]             buttons,
	output logic                   forced_scandoubler,
	output logic                   direct_video
);

	import hps_bus_pkg::*;
	import hps_core_pkg::*;

	joy_t       joy_q [6];
	status_t    status_q;
	cfg_t       cfg_q;
	status_t    status_req_q;
	logic [3:0] req_cnt_q;
	logic       status_set_q;
	logic       joy_hit;
	logic [2:0] joy_sel;
	logic       pay_stb;
	word_t      rd_word;

	// payload words only, command word is handled by the framer
	assign pay_stb = word_stb && (word_idx != '0);

	// joystick command to slot
	always_comb begin
		joy_hit = 1'b1;
		joy_sel = 3'd0;
		case (cmd)
			CMD_JOY0: joy_sel = 3'd0;
			CMD_JOY1: joy_sel = 3'd1;
			CMD_JOY2: joy_sel = 3'd2;
			CMD_JOY3: joy_sel = 3'd3;
			CMD_JOY4: joy_sel = 3'd4;
			CMD_JOY5: joy_sel = 3'd5;
			default: joy_hit = 1'b0;
		endcase
	end

	//////////////////////////////
	// register writes
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 6; i++) begin
				joy_q[i] <= '0;
			end
			status_q <= '0;
			cfg_q    <= '0;
		end else if (pay_stb) begin
			if (joy_hit) begin
				// low half first
				if (word_idx == 4'd1) joy_q[joy_sel][15:0]  <= din;
				if (word_idx == 4'd2) joy_q[joy_sel][31:16] <= din;
			end
			if (cmd == CMD_STATUS) begin
				case (word_idx)
					4'd1: status_q[15:0]  <= din;
					4'd2: status_q[31:16] <= din;
					4'd3: status_q[47:32] <= din;
					4'd4: status_q[63:48] <= din;
					default: ;
				endcase
			end
			if ((cmd == CMD_CFG) && (word_idx == 4'd1)) cfg_q <= din;
		end
	end

	//////////////////////////////
	// status request capture
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			status_set_q <= 1'b0;
			req_cnt_q    <= '0;
			status_req_q <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set && !status_set_q) begin
				req_cnt_q    <= req_cnt_q + 4'd1;
				status_req_q <= status_in;
			end
		end
	end

	//////////////////////////////
	// readback
	//////////////////////////////

	always_comb begin
		rd_word = '0;
		if (word_idx == '0) begin
			// command word itself, din holds the code
			if (din == CMD_STATUS_REQ) rd_word = {8'h00, STATUS_REQ_TAG, req_cnt_q};
		end else begin
			case (cmd)
				CMD_STATUS_REQ: begin
					case (word_idx)
						4'd1: rd_word = status_req_q[15:0];
						4'd2: rd_word = status_req_q[31:16];
						4'd3: rd_word = status_req_q[47:32];
						4'd4: rd_word = status_req_q[63:48];
						default: ;
					endcase
				end
				CMD_MENUMASK: if (word_idx == 4'd1) rd_word = status_menumask;
				default: ;
			endcase
		end
	end

	// idle channel shows word 0 and clears the reply
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			io_dout <= '0;
		end else if (word_stb) begin
			io_dout <= rd_word;
		end else if (word_idx == '0) begin
			io_dout <= '0;
		end
	end

	assign joystick_0 = joy_q[0];
	assign joystick_1 = joy_q[1];
	assign joystick_2 = joy_q[2];
	assign joystick_3 = joy_q[3];
	assign joystick_4 = joy_q[4];
	assign joystick_5 = joy_q[5];
	assign status     = status_q;

	// cfg bit map
	assign buttons            = cfg_q[1:0];
	assign forced_scandoubler = cfg_q[4];
	assign direct_video       = cfg_q[10];

endmodule

//--- fio_download.sv
// file-io command handling with file index, extension and download address generation
module fio_download (
	input  logic                       clk_sys,
	input  logic                       arst_n,
	input  logic                       word_stb,
	input  hps_bus_pkg::word_t         cmd,
	input  hps_bus_pkg::word_idx_t     word_idx,
	input  hps_bus_pkg::word_t         din,
	output logic                       ioctl_download,
	output hps_bus_pkg::word_t         ioctl_index,
	output hps_core_pkg::file_ext_t    ioctl_file_ext,
	output logic                       push,
	output hps_core_pkg::ioctl_addr_t  push_addr,
	output hps_core_pkg::ioctl_data_t  push_data
);

	import hps_bus_pkg::*;
	import hps_core_pkg::*;

	ioctl_addr_t addr_q;
	logic        pay_stb;
	logic        dat_hit;

	assign pay_stb = word_stb && (word_idx != '0);

	// data words count only inside a download
	assign dat_hit = pay_stb && (cmd == FIO_FILE_TX_DAT) && ioctl_download;

	//////////////////////////////
	// command registers
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			addr_q         <= '0;
		end else if (pay_stb) begin
			case (cmd)
				FIO_FILE_INDEX: begin
					if (word_idx == 4'd1) ioctl_index <= din;
				end
				FIO_FILE_INFO: begin
					// extension arrives high half first
					if (word_idx == 4'd1) ioctl_file_ext[31:16] <= din;
					if (word_idx == 4'd2) ioctl_file_ext[15:0]  <= din;
				end
				FIO_FILE_TX: begin
					case (word_idx)
						4'd1: begin
							if (din[7:0] != 8'h00) begin
								ioctl_download <= 1'b1;
								addr_q         <= '0;
							end else begin
								ioctl_download <= 1'b0;
							end
						end
						4'd2: addr_q[15:0]  <= din;
						4'd3: addr_q[26:16] <= din[10:0];
						default: ;
					endcase
				end
				FIO_FILE_TX_DAT: begin
					if (ioctl_download) addr_q <= addr_q + ADDR_STEP;
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////
	// buffer push
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			push <= 1'b0;
		end else begin
			push <= dat_hit;
		end
	end

	// address before the step goes with the word
	always_ff @(posedge clk_sys) begin
		if (dat_hit) begin
			push_addr <= addr_q;
			push_data <= din;
		end
	end

endmodule

//--- ioctl_credit_buffer.sv
// download word buffer that delivers writes to the core against returned credits
module ioctl_credit_buffer (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      push,
	input  hps_core_pkg::ioctl_addr_t push_addr,
	input  hps_core_pkg::ioctl_data_t push_data,
	input  logic                      ioctl_credit,
	output logic                      host_busy,
	output logic                      ioctl_wr,
	output hps_core_pkg::ioctl_addr_t ioctl_addr,
	output hps_core_pkg::ioctl_data_t ioctl_dout
);

	import hps_core_pkg::*;

	ioctl_addr_t addr_mem [BUF_DEPTH];
	ioctl_data_t data_mem [BUF_DEPTH];

	logic [$clog2(BUF_DEPTH)-1:0] wr_ptr;
	logic [$clog2(BUF_DEPTH)-1:0] rd_ptr;
	buf_cnt_t fill;
	credit_t  credit;
	logic     push_ok;
	logic     issue;

	assign push_ok = push && (fill != buf_cnt_t'(BUF_DEPTH));
	assign issue   = (fill != '0) && (credit != '0);

	// one slot kept free for a word still in flight
	assign host_busy = (fill >= buf_cnt_t'(BUF_DEPTH - 1));

	always_ff @(posedge clk_sys) begin
		if (push_ok) begin
			addr_mem[wr_ptr] <= push_addr;
			data_mem[wr_ptr] <= push_data;
		end
	end

	//////////////////////////////
	// pointers, fill and credits
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fill     <= '0;
			credit   <= CORE_CREDITS;
			ioctl_wr <= 1'b0;
		end else begin
			if (push_ok) wr_ptr <= wr_ptr + 2'd1;
			if (issue) rd_ptr <= rd_ptr + 2'd1;
			case ({push_ok, issue})
				2'b10: fill <= fill + 3'd1;
				2'b01: fill <= fill - 3'd1;
				default: ;
			endcase
			// a write spends one credit and a credit pulse returns one
			case ({issue, ioctl_credit})
				2'b10: credit <= credit - 2'd1;
				2'b01: credit <= credit + 2'd1;
				default: ;
			endcase
			ioctl_wr <= issue;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (issue) begin
			ioctl_addr <= addr_mem[rd_ptr];
			ioctl_dout <= data_mem[rd_ptr];
		end
	end

endmodule

//--- hps_link_top.sv
// host-to-core link top with framers, user-io registers, download path and buffer
module hps_link_top (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      io_enable,
	input  logic                      fp_enable,
	input  logic                      io_strobe,
	input  hps_bus_pkg::word_t        io_din,
	output hps_bus_pkg::word_t        io_dout,
	output logic                      host_busy,
	input  hps_core_pkg::status_t     status_in,
	input  logic                      status_set,
	input  hps_bus_pkg::word_t        status_menumask,
	output hps_core_pkg::joy_t        joystick_0,
	output hps_core_pkg::joy_t        joystick_1,
	output hps_core_pkg::joy_t        joystick_2,
	output hps_core_pkg::joy_t        joystick_3,
	output hps_core_pkg::joy_t        joystick_4,
	output hps_core_pkg::joy_t        joystick_5,
	output hps_core_pkg::status_t     status,
	output logic [1:0]                buttons,
	output logic                      forced_scandoubler,
	output logic                      direct_video,
	output logic                      ioctl_download,
	output hps_bus_pkg::word_t        ioctl_index,
	output hps_core_pkg::file_ext_t   ioctl_file_ext,
	output logic                      ioctl_wr,
	output hps_core_pkg::ioctl_addr_t ioctl_addr,
	output hps_core_pkg::ioctl_data_t ioctl_dout,
	input  logic                      ioctl_credit
);

	import hps_bus_pkg::*;
	import hps_core_pkg::*;

	logic        uio_stb;
	word_t       uio_cmd;
	word_idx_t   uio_idx;
	logic        fio_stb;
	word_t       fio_cmd;
	word_idx_t   fio_idx;
	logic        push;
	ioctl_addr_t push_addr;
	ioctl_data_t push_data;

	//////////////////////////////
	// channel framers
	//////////////////////////////

	hps_cmd_framer uio_framer_i (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.enable   (io_enable),
		.strobe   (io_strobe),
		.din      (io_din),
		.word_stb (uio_stb),
		.cmd      (uio_cmd),
		.word_idx (uio_idx)
	);

	hps_cmd_framer fio_framer_i (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.enable   (fp_enable),
		.strobe   (io_strobe),
		.din      (io_din),
		.word_stb (fio_stb),
		.cmd      (fio_cmd),
		.word_idx (fio_idx)
	);

	//////////////////////////////
	// user-io and file-io
	//////////////////////////////

	uio_regs uio_regs_i (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.word_stb           (uio_stb),
		.cmd                (uio_cmd),
		.word_idx           (uio_idx),
		.din                (io_din),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask),
		.io_dout            (io_dout),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.joystick_4         (joystick_4),
		.joystick_5         (joystick_5),
		.status             (status),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video)
	);

	fio_download fio_download_i (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.word_stb       (fio_stb),
		.cmd            (fio_cmd),
		.word_idx       (fio_idx),
		.din            (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.push           (push),
		.push_addr      (push_addr),
		.push_data      (push_data)
	);

	// download words towards the core
	ioctl_credit_buffer ioctl_credit_buffer_i (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.push         (push),
		.push_addr    (push_addr),
		.push_data    (push_data),
		.ioctl_credit (ioctl_credit),
		.host_busy    (host_busy),
		.ioctl_wr     (ioctl_wr),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout)
	);

endmodule

//--- tb_clock_gen.sv
// testbench clock and reset source, 4-unit period with reset held for 8 cycles
module tb_clock_gen (
	output logic clk_sys,
	output logic arst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// release just after the eighth rising edge
	initial begin
		arst_n = 1'b0;
		repeat (8) @(posedge clk_sys);
		#1;
		arst_n = 1'b1;
	end

endmodule

//--- hps_link_tb.sv
// testbench for the host link with random transfers checked against a reference model
module hps_link_tb;

	import hps_bus_pkg::*;
	import hps_core_pkg::*;

	localparam int STEP_LIMIT = 200;
	localparam int DL_WORDS   = 20;

	logic        clk_sys;
	logic        arst_n;
	logic        io_enable;
	logic        fp_enable;
	logic        io_strobe;
	word_t       io_din;
	word_t       io_dout;
	logic        host_busy;
	status_t     status_in;
	logic        status_set;
	word_t       status_menumask;
	joy_t        joystick_0;
	joy_t        joystick_1;
	joy_t        joystick_2;
	joy_t        joystick_3;
	joy_t        joystick_4;
	joy_t        joystick_5;
	status_t     status;
	logic [1:0]  buttons;
	logic        forced_scandoubler;
	logic        direct_video;
	logic        ioctl_download;
	word_t       ioctl_index;
	file_ext_t   ioctl_file_ext;
	logic        ioctl_wr;
	ioctl_addr_t ioctl_addr;
	ioctl_data_t ioctl_dout;
	logic        ioctl_credit;

	// reference model
	logic [31:0] lfsr;
	joy_t        m_joy [6];
	status_t     m_status;
	cfg_t        m_cfg;
	status_t     m_req;
	logic [3:0]  m_req_cnt;
	word_t       m_index;
	file_ext_t   m_ext;
	ioctl_addr_t exp_addr [$];
	ioctl_data_t exp_data [$];
	int          m_credits;
	int          owed;
	int          credit_wait;
	int          wr_count;
	int          value_errs;
	int          other_errs;

	tb_clock_gen clock_gen_i (
		.clk_sys (clk_sys),
		.arst_n  (arst_n)
	);

	hps_link_top hps_link_top_i (.*);

	//////////////////////////////
	// random numbers
	//////////////////////////////

	// taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r = {r[62:0], lfsr[0]};
		end
		return r;
	endfunction

	//////////////////////////////
	// compare and report
	//////////////////////////////

	task automatic check_joy(input string name, input joy_t exp, input joy_t act);
		if (exp !== act) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_status(input string name, input status_t exp, input status_t act);
		if (exp !== act) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_ext(input string name, input file_ext_t exp, input file_ext_t act);
		if (exp !== act) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_addr(input string name, input ioctl_addr_t exp, input ioctl_addr_t act);
		if (exp !== act) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_data(input string name, input ioctl_data_t exp, input ioctl_data_t act);
		if (exp !== act) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			value_errs++;
		end
	endtask

	task automatic report(input string what);
		$display("error: %s", what);
		other_errs++;
	endtask

	task automatic finish_run();
		$display("errors: %0d wrong values, %0d other", value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	endtask

	//////////////////////////////
	// core side model
	//////////////////////////////

	// core model takes writes and hands credits back after random delays
	task automatic core_tick();
		if (ioctl_wr) begin
			if (m_credits == 0) begin
				report("ioctl_wr issued with no credit left");
			end else begin
				m_credits--;
			end
			if (exp_addr.size() == 0) begin
				report("ioctl_wr with no download word expected");
			end else begin
				check_addr("download address", exp_addr.pop_front(), ioctl_addr);
				check_data("download data", exp_data.pop_front(), ioctl_dout);
			end
			owed++;
			wr_count++;
		end
		// pulse from last cycle has reached the DUT by now
		if (ioctl_credit) begin
			m_credits++;
			ioctl_credit = 1'b0;
		end
		if (owed > 0) begin
			if (credit_wait == 0) begin
				ioctl_credit = 1'b1;
				owed--;
				credit_wait = 1 + int'(rand_bits(2));
			end else begin
				credit_wait--;
			end
		end
	endtask

	// inputs change 1 unit after the edge
	task automatic clock_step();
		@(posedge clk_sys);
		#1;
		core_tick();
	endtask

	//////////////////////////////
	// host side
	//////////////////////////////

	task automatic open_channel(input logic fp);
		io_enable = !fp;
		fp_enable = fp;
		clock_step();
	endtask

	task automatic close_channel();
		io_enable = 1'b0;
		fp_enable = 1'b0;
		clock_step();
	endtask

	// reply is taken one cycle after the strobe and followed by one idle cycle
	task automatic send_word(input word_t w, output word_t rd);
		io_din = w;
		io_strobe = 1'b1;
		clock_step();
		rd = io_dout;
		io_strobe = 1'b0;
		clock_step();
	endtask

	task automatic send_transfer(input logic fp, input word_t cmd, input word_t pay [6],
		input int n);
		word_t rd;
		open_channel(fp);
		send_word(cmd, rd);
		for (int i = 0; i < n; i++) begin
			send_word(pay[i], rd);
		end
		close_channel();
	endtask

	task automatic wait_not_busy();
		int n;
		n = 0;
		while (host_busy && n < STEP_LIMIT) begin
			clock_step();
			n++;
		end
		if (host_busy) begin
			report("timeout waiting for host_busy to drop");
		end
	endtask

	task automatic wait_writes(input int total);
		int n;
		n = 0;
		while (wr_count < total && n < STEP_LIMIT) begin
			clock_step();
			n++;
		end
		if (wr_count < total) begin
			report("timeout waiting for download writes to reach the core");
		end
	endtask

	function automatic joy_t joy_out(input int i);
		case (i)
			0: return joystick_0;
			1: return joystick_1;
			2: return joystick_2;
			3: return joystick_3;
			4: return joystick_4;
			default: return joystick_5;
		endcase
	endfunction

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		word_t       pay [6];
		word_t       rd;
		word_t       joy_cmds [6];
		ioctl_addr_t start;
		int          n;
		int          pulses;

		joy_cmds = '{CMD_JOY0, CMD_JOY1, CMD_JOY2, CMD_JOY3, CMD_JOY4, CMD_JOY5};
		lfsr = 32'h93fe_d6d3;
		io_enable = 1'b0;
		fp_enable = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		status_in = '0;
		status_set = 1'b0;
		status_menumask = '0;
		ioctl_credit = 1'b0;
		for (int i = 0; i < 6; i++) begin
			m_joy[i] = '0;
			pay[i] = '0;
		end
		m_status = '0;
		m_cfg = '0;
		m_req = '0;
		m_req_cnt = '0;
		m_credits = int'(CORE_CREDITS);
		owed = 0;
		credit_wait = 0;
		wr_count = 0;
		value_errs = 0;
		other_errs = 0;

		n = 0;
		while (!arst_n && n < STEP_LIMIT) begin
			clock_step();
			n++;
		end
		if (!arst_n) begin
			report("timeout waiting for reset release");
		end
		clock_step();
		check_word("reset io_dout", '0, io_dout);
		check_joy("reset joystick_0", '0, joystick_0);
		check_status("reset status", '0, status);
		if (ioctl_wr || ioctl_download || host_busy) begin
			report("core side outputs not low after reset");
		end

		// two rounds of joystick writes over all six
		for (int r = 0; r < 2; r++) begin
			for (int j = 0; j < 6; j++) begin
				m_joy[j] = joy_t'(rand_bits(32));
				pay[0] = m_joy[j][15:0];
				pay[1] = m_joy[j][31:16];
				send_transfer(1'b0, joy_cmds[j], pay, 2);
				for (int k = 0; k < 6; k++) begin
					check_joy($sformatf("joystick_%0d after cmd %h", k, joy_cmds[j]),
						m_joy[k], joy_out(k));
				end
			end
		end

		// status takes only words 1 to 4
		for (int i = 0; i < 6; i++) begin
			pay[i] = word_t'(rand_bits(16));
		end
		m_status = {pay[3], pay[2], pay[1], pay[0]};
		send_transfer(1'b0, CMD_STATUS, pay, 6);
		check_status("status write", m_status, status);
		m_cfg = cfg_t'(rand_bits(16));
		pay[0] = m_cfg;
		send_transfer(1'b0, CMD_CFG, pay, 1);
		check_word("cfg outputs", {12'd0, m_cfg[10], m_cfg[4], m_cfg[1:0]},
			{12'd0, direct_video, forced_scandoubler, buttons});

		// status requests
		for (int r = 0; r < 2; r++) begin
			pulses = 1 + int'(rand_bits(3));
			for (int p = 0; p < pulses; p++) begin
				status_in = status_t'(rand_bits(64));
				status_set = 1'b1;
				clock_step();
				status_set = 1'b0;
				m_req = status_in;
				m_req_cnt = m_req_cnt + 4'd1;
				repeat (1 + int'(rand_bits(2))) clock_step();
			end
			open_channel(1'b0);
			send_word(CMD_STATUS_REQ, rd);
			check_word("status request tag", {8'h00, STATUS_REQ_TAG, m_req_cnt}, rd);
			for (int w = 0; w < 4; w++) begin
				send_word(16'h0000, rd);
				check_word($sformatf("status request word %0d", w + 1), m_req[16*w +: 16], rd);
			end
			close_channel();
			check_word("io_dout after transfer", '0, io_dout);
		end
		status_menumask = word_t'(rand_bits(16));
		open_channel(1'b0);
		send_word(CMD_MENUMASK, rd);
		send_word(16'h0000, rd);
		check_word("menu mask read", status_menumask, rd);
		close_channel();

		// file index and extension
		m_index = word_t'(rand_bits(16));
		pay[0] = m_index;
		send_transfer(1'b1, FIO_FILE_INDEX, pay, 1);
		check_word("file index", m_index, ioctl_index);
		m_ext = file_ext_t'(rand_bits(32));
		pay[0] = m_ext[31:16];
		pay[1] = m_ext[15:0];
		send_transfer(1'b1, FIO_FILE_INFO, pay, 2);
		check_ext("file extension", m_ext, ioctl_file_ext);

		// download with credit flow control
		start = ioctl_addr_t'(rand_bits(27));
		pay[0] = word_t'(rand_bits(8)) | 16'h0001;
		pay[1] = start[15:0];
		pay[2] = {5'd0, start[26:16]};
		send_transfer(1'b1, FIO_FILE_TX, pay, 3);
		if (!ioctl_download) begin
			report("ioctl_download not set by download start");
		end
		open_channel(1'b1);
		send_word(FIO_FILE_TX_DAT, rd);
		for (int i = 0; i < DL_WORDS; i++) begin
			wait_not_busy();
			pay[0] = word_t'(rand_bits(16));
			exp_addr.push_back(start + ioctl_addr_t'(2 * i));
			exp_data.push_back(pay[0]);
			send_word(pay[0], rd);
		end
		close_channel();
		wait_writes(DL_WORDS);
		pay[0] = 16'h0000;
		send_transfer(1'b1, FIO_FILE_TX, pay, 1);
		if (ioctl_download) begin
			report("ioctl_download still set after download stop");
		end
		finish_run();
	end

endmodule

//--- hps_link.f
hps_bus_pkg.sv
hps_core_pkg.sv
hps_cmd_framer.sv
uio_regs.sv
fio_download.sv
ioctl_credit_buffer.sv
hps_link_top.sv
tb_clock_gen.sv
hps_link_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --top-module hps_link_tb -f hps_link.f -o vsim
	@out="$$(./obj_dir/vsim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir
